// ==== dispatcher.f ====
+incdir+common
common/dispatcher_pkg.sv
src/dispatch_ctl.sv
src/cpu_scheduler.sv
src/mem_bridge.sv
src/dispatcher_top.sv
tests/tb_dispatcher.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dispatcher testbench, verdict taken from the simulation log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dispatcher -f dispatcher.f \
  && ./obj_dir/Vtb_dispatcher > sim.log 2>&1 \
  || { echo "build or simulation error"; exit 1; }

cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0

// ==== tests/tb_dispatcher.sv ====
`timescale 1ns/1ps

`include "dispatcher_cfg.svh"

module tb_dispatcher;

  localparam int NUM_TXN     = 60;
  // roughly 60 transactions of up to 40 cycles with margin
  localparam int CYCLE_LIMIT = 3000;

  logic                     clk = 1'b0;
  logic                     ext_rst_e;
  logic                     ext_rst_b;
  logic [`DISP_ADDR_W-1:0]  addr_in;
  logic [`DISP_DATA_W-1:0]  data_in;
  logic [`DISP_ADDR_W-1:0]  addr_out;
  logic [`DISP_DATA_W-1:0]  data_out;
  logic                     read_q;
  logic                     write_q;
  logic                     read_dn;
  logic                     write_dn;
  logic                     rw_halt_in;
  logic                     rw_halt_out;
  logic                     ext_cpu_q;
  logic                     ext_cpu_e;
  dispatcher_pkg::cpu_idx_t ext_cpu_index;
  dispatcher_pkg::cpu_msg_t cpu_msg_in;
  logic [`DISP_ADDR_W-1:0]  ext_mem_addr_out;
  logic [`DISP_DATA_W-1:0]  ext_mem_data_out;
  logic [`DISP_ADDR_W-1:0]  ext_mem_addr_in;
  logic [`DISP_DATA_W-1:0]  ext_mem_data_in;
  logic                     ext_read_q;
  logic                     ext_write_q;
  logic                     ext_read_dn;
  logic                     ext_write_dn;
  logic                     ext_rw_halt_in;
  logic                     ext_rw_halt_out;
  logic                     ext_bus_q;
  logic                     ext_bus_allow;

  // one error counter per checking process
  int drv_errors = 0;
  int mon_errors = 0;
  int cycles     = 0;

  logic [31:0] rng;
  // 16-word model memory
  logic [`DISP_DATA_W-1:0] mem [0:15];

  // scheduler reference state
  dispatcher_pkg::cpu_cnt_t m_act;
  dispatcher_pkg::cpu_cnt_t m_inact;
  dispatcher_pkg::cpu_cnt_t m_num;
  logic                     m_slot;

  // all single-cycle outputs side by side
  logic [6:0] strobes;
  logic [6:0] p_strobes;
  logic       p_bus_q;
  logic       p_allow;
  logic       p_rd_dn_in;
  logic       p_wr_dn_in;
  logic       p_halt_in;
  logic       p_ext_halt_in;

  assign strobes = {ext_cpu_q, ext_read_q, ext_write_q, read_dn, write_dn,
                    rw_halt_out, ext_rw_halt_out};

  dispatcher_top dut (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // inputs change 1 ns after the edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      drv_errors++;
      $display("Fail %s: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic print_counts();
    $display("errors: %0d in sequence checks, %0d in protocol checks, %0d cycles",
             drv_errors, mon_errors, cycles);
  endtask

  task automatic check_quiet(input logic rst_b_exp);
    expect_eq("ext_rst_b", 32'(rst_b_exp), 32'(ext_rst_b));
    expect_eq("strobes", 32'd0, 32'(strobes));
    expect_eq("ext_bus_allow", 32'd0, 32'(ext_bus_allow));
  endtask

  // next index per the scheduling rule
  task automatic predict_index(output dispatcher_pkg::cpu_idx_t idx);
    dispatcher_pkg::cpu_cnt_t last;
    last = m_act - 8'd1;
    if ((m_inact != '0) && !m_slot) begin
      idx    = `DISP_CPU_NONACTIVE;
      m_slot = 1'b1;
    end else begin
      m_slot = 1'b0;
      if (m_num >= last) begin
        m_num = '0;
      end else begin
        m_num = m_num + 8'd1;
      end
      idx = m_num | `DISP_CPU_ACTIVE;
    end
  endtask

  // cpu reports a message and the model follows
  task automatic answer_msg(input dispatcher_pkg::cpu_msg_t msg);
    ext_cpu_e  = 1'b1;
    cpu_msg_in = msg;
    tick();
    ext_cpu_e  = 1'b0;
    cpu_msg_in = dispatcher_pkg::msg_none;
    if (msg == dispatcher_pkg::msg_start) begin
      m_inact = m_inact - 8'd1;
      m_act   = m_act + 8'd1;
      m_num   = m_num + 8'd1;
      m_slot  = 1'b0;
    end else if (msg == dispatcher_pkg::msg_end) begin
      m_act   = m_act - 8'd1;
      m_inact = m_inact + 8'd1;
    end
  endtask

  // halt_kind 0 completes, 1 halts from the cpu, 2 halts from memory
  task automatic mem_access(input logic is_wr, input int halt_kind);
    logic [3:0]  widx;
    logic [31:0] a;
    logic [31:0] d;
    rng  = xorshift32(rng);
    widx = rng[3:0];
    a    = {26'd0, widx, 2'b00};
    d    = rng ^ 32'hC3C3_0F0F;
    addr_in = a;
    data_in = d;
    read_q  = !is_wr;
    write_q = is_wr;
    tick();
    read_q  = 1'b0;
    write_q = 1'b0;
    // scramble the cpu side since the request must stay latched
    addr_in = ~a;
    data_in = ~d;
    expect_eq("ext_read_q", 32'(!is_wr), 32'(ext_read_q));
    expect_eq("ext_write_q", 32'(is_wr), 32'(ext_write_q));
    expect_eq("ext_mem_addr_out", a, ext_mem_addr_out);
    if (is_wr) begin
      expect_eq("ext_mem_data_out", d, ext_mem_data_out);
      mem[widx] = d;
    end
    // memory latency
    rng = xorshift32(rng);
    repeat (rng % 8) tick();
    if (halt_kind != 0) begin
      rw_halt_in     = (halt_kind == 1);
      ext_rw_halt_in = (halt_kind == 2);
      tick();
      rw_halt_in     = 1'b0;
      ext_rw_halt_in = 1'b0;
      // late done after the halt must be ignored
      ext_read_dn  = !is_wr;
      ext_write_dn = is_wr;
      expect_eq("ext_rw_halt_out", 32'(halt_kind == 1), 32'(ext_rw_halt_out));
      expect_eq("rw_halt_out", 32'(halt_kind == 2), 32'(rw_halt_out));
      tick();
      ext_read_dn  = 1'b0;
      ext_write_dn = 1'b0;
      expect_eq("ext_rw_halt_out", 32'd0, 32'(ext_rw_halt_out));
      expect_eq("rw_halt_out", 32'd0, 32'(rw_halt_out));
      expect_eq("read_dn", 32'd0, 32'(read_dn));
      expect_eq("write_dn", 32'd0, 32'(write_dn));
    end else begin
      ext_read_dn     = !is_wr;
      ext_write_dn    = is_wr;
      ext_mem_addr_in = a;
      ext_mem_data_in = mem[widx];
      tick();
      ext_read_dn     = 1'b0;
      ext_write_dn    = 1'b0;
      ext_mem_addr_in = rng;
      ext_mem_data_in = ~rng;
      expect_eq("read_dn", 32'(!is_wr), 32'(read_dn));
      expect_eq("write_dn", 32'(is_wr), 32'(write_dn));
      expect_eq("addr_out", a, addr_out);
      expect_eq("data_out", mem[widx], data_out);
      tick();
      // finish cycle drops the results
      expect_eq("read_dn", 32'd0, 32'(read_dn));
      expect_eq("write_dn", 32'd0, 32'(write_dn));
      expect_eq("addr_out", 32'd0, addr_out);
      expect_eq("data_out", 32'd0, data_out);
    end
  endtask

  task automatic bus_grant();
    int hold;
    rng  = xorshift32(rng);
    hold = rng % 4;
    ext_bus_q = 1'b1;
    tick();
    tick();
    // one cycle to enter the bus state and one to register the grant
    expect_eq("ext_bus_allow", 32'd1, 32'(ext_bus_allow));
    repeat (hold) tick();
    ext_bus_q = 1'b0;
    tick();
    expect_eq("ext_bus_allow", 32'd0, 32'(ext_bus_allow));
  endtask

  // protocol watcher and cycle limit
  always @(posedge clk) begin
    cycles        <= cycles + 1;
    p_strobes     <= strobes;
    p_bus_q       <= ext_bus_q;
    p_allow       <= ext_bus_allow;
    p_rd_dn_in    <= ext_read_dn;
    p_wr_dn_in    <= ext_write_dn;
    p_halt_in     <= rw_halt_in;
    p_ext_halt_in <= ext_rw_halt_in;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      print_counts();
      $display("*** TEST FAILED ***");
      $finish;
    end else if (cycles >= 3) begin
      assert (!ext_rst_b) else begin
        mon_errors++;
        $display("Fail ext_rst_b: expected %h, got %h", 1'b0, ext_rst_b);
      end
      assert ((strobes & p_strobes) == 7'd0) else begin
        mon_errors++;
        $display("a strobe stayed high for two cycles, mask %h", strobes & p_strobes);
      end
      assert (!(ext_cpu_q && p_bus_q)) else begin
        mon_errors++;
        $display("cpu poll issued during an external bus request");
      end
      assert (!ext_bus_allow || p_bus_q) else begin
        mon_errors++;
        $display("bus grant present without a request");
      end
      assert (!(p_allow && p_bus_q && !ext_bus_allow)) else begin
        mon_errors++;
        $display("bus grant dropped while the request was held");
      end
      assert ((!read_dn || p_rd_dn_in) && (!write_dn || p_wr_dn_in)) else begin
        mon_errors++;
        $display("completion reported without a memory done pulse");
      end
      assert ((!ext_rw_halt_out || p_halt_in) && (!rw_halt_out || p_ext_halt_in)) else begin
        mon_errors++;
        $display("halt reflected without a halt on the other side");
      end
    end
  end

  initial begin
    dispatcher_pkg::cpu_idx_t idx;
    int                       halt;
    ext_rst_e       = 1'b1;
    addr_in         = '0;
    data_in         = '0;
    read_q          = 1'b0;
    write_q         = 1'b0;
    rw_halt_in      = 1'b0;
    ext_cpu_e       = 1'b0;
    cpu_msg_in      = dispatcher_pkg::msg_none;
    ext_mem_addr_in = '0;
    ext_mem_data_in = '0;
    ext_read_dn     = 1'b0;
    ext_write_dn    = 1'b0;
    ext_rw_halt_in  = 1'b0;
    ext_bus_q       = 1'b0;
    rng     = 32'd85;
    m_act   = '0;
    m_inact = dispatcher_pkg::cpu_cnt_t'(`DISP_CPU_QUANTITY);
    m_num   = '0;
    m_slot  = 1'b0;
    for (int i = 0; i < 16; i++) begin
      mem[i] = 32'h5A5A_0000 + i * 32'h0001_0011;
    end

    // two reset cycles and then one wait cycle with cpus still held
    tick();
    check_quiet(1'b1);
    tick();
    check_quiet(1'b1);
    ext_rst_e = 1'b0;
    tick();
    check_quiet(1'b0);

    for (int t = 0; t < NUM_TXN; t++) begin
      while (!ext_cpu_q) tick();
      predict_index(idx);
      expect_eq("ext_cpu_index", 32'(idx), 32'(ext_cpu_index));
      // cpu think time
      rng = xorshift32(rng);
      repeat (rng % 3) tick();
      rng  = xorshift32(rng);
      halt = (rng[7:4] == 4'd0) ? 1 : ((rng[7:4] == 4'd1) ? 2 : 0);
      if (idx == `DISP_CPU_NONACTIVE) begin
        // an idle cpu sometimes lets its restart slot pass
        if ((m_act != '0) && rng[3]) begin
          answer_msg(dispatcher_pkg::msg_none);
        end else begin
          answer_msg(dispatcher_pkg::msg_start);
        end
      end else begin
        case (rng[2:0])
          3'd0: begin
            if (m_act > 8'd1) begin
              answer_msg(dispatcher_pkg::msg_end);
            end else begin
              mem_access(1'b0, halt);
            end
          end
          3'd1: answer_msg(dispatcher_pkg::msg_none);
          3'd2, 3'd3, 3'd4: mem_access(1'b0, halt);
          default: mem_access(1'b1, halt);
        endcase
      end
      // external master now and then
      rng = xorshift32(rng);
      if (rng[2:0] == 3'd0) begin
        bus_grant();
      end
    end

    repeat (4) tick();
    print_counts();
    if (drv_errors == 0 && mon_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== src/dispatcher_top.sv ====
`timescale 1ns/1ps

`include "dispatcher_cfg.svh"

module dispatcher_top (
  input  logic                         clk,
  input  logic                         ext_rst_e,
  output logic                         ext_rst_b,
  // cpu request side
  input  logic [`DISP_ADDR_W-1:0]      addr_in,
  input  logic [`DISP_DATA_W-1:0]      data_in,
  output logic [`DISP_ADDR_W-1:0]      addr_out,
  output logic [`DISP_DATA_W-1:0]      data_out,
  input  logic                         read_q,
  input  logic                         write_q,
  output logic                         read_dn,
  output logic                         write_dn,
  input  logic                         rw_halt_in,
  output logic                         rw_halt_out,
  // cpu polling
  output logic                         ext_cpu_q,
  input  logic                         ext_cpu_e,
  output dispatcher_pkg::cpu_idx_t     ext_cpu_index,
  input  dispatcher_pkg::cpu_msg_t     cpu_msg_in,
  // external memory
  output logic [`DISP_ADDR_W-1:0]      ext_mem_addr_out,
  output logic [`DISP_DATA_W-1:0]      ext_mem_data_out,
  input  logic [`DISP_ADDR_W-1:0]      ext_mem_addr_in,
  input  logic [`DISP_DATA_W-1:0]      ext_mem_data_in,
  output logic                         ext_read_q,
  output logic                         ext_write_q,
  input  logic                         ext_read_dn,
  input  logic                         ext_write_dn,
  input  logic                         ext_rw_halt_in,
  output logic                         ext_rw_halt_out,
  // external bus master
  input  logic                         ext_bus_q,
  output logic                         ext_bus_allow
);

  // ctl to scheduler
  logic sched_step;
  logic sched_msg_ev;
  // ctl to memory bridge
  logic mem_start_rd;
  logic mem_start_wr;
  logic mem_clear;
  // memory bridge events back to ctl
  logic mem_done_rd;
  logic mem_done_wr;
  logic mem_halt_cpu;
  logic mem_halt_ext;

  dispatch_ctl u_ctl (.*);

  cpu_scheduler u_sched (.*);

  mem_bridge u_mem (.*);

endmodule

// ==== src/mem_bridge.sv ====
`timescale 1ns/1ps

`include "dispatcher_cfg.svh"

module mem_bridge (
  input  logic                    clk,
  input  logic                    ext_rst_e,
  input  logic                    mem_start_rd,
  input  logic                    mem_start_wr,
  input  logic                    mem_clear,
  input  logic [`DISP_ADDR_W-1:0] addr_in,
  input  logic [`DISP_DATA_W-1:0] data_in,
  input  logic [`DISP_ADDR_W-1:0] ext_mem_addr_in,
  input  logic [`DISP_DATA_W-1:0] ext_mem_data_in,
  input  logic                    ext_read_dn,
  input  logic                    ext_write_dn,
  input  logic                    rw_halt_in,
  input  logic                    ext_rw_halt_in,
  output logic                    ext_read_q,
  output logic                    ext_write_q,
  output logic [`DISP_ADDR_W-1:0] ext_mem_addr_out,
  output logic [`DISP_DATA_W-1:0] ext_mem_data_out,
  output logic [`DISP_ADDR_W-1:0] addr_out,
  output logic [`DISP_DATA_W-1:0] data_out,
  output logic                    mem_done_rd,
  output logic                    mem_done_wr,
  output logic                    mem_halt_cpu,
  output logic                    mem_halt_ext
);

  logic                    pend_rd;
  logic                    pend_wr;
  logic                    pending;
  logic                    halt_any;
  logic [`DISP_ADDR_W-1:0] req_addr;
  logic [`DISP_DATA_W-1:0] req_data;

  assign pending = pend_rd | pend_wr;

  // halts only count while an access is open, cpu side first
  assign mem_halt_cpu = pending & rw_halt_in;
  assign mem_halt_ext = pending & ext_rw_halt_in & ~rw_halt_in;
  assign halt_any     = mem_halt_cpu | mem_halt_ext;

  assign mem_done_rd = pend_rd & ext_read_dn & ~halt_any;
  assign mem_done_wr = pend_wr & ext_write_dn & ~halt_any;

  // address bus idles at zero
  assign ext_mem_addr_out = pending ? req_addr : '0;
  assign ext_mem_data_out = req_data;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      pend_rd     <= 1'b0;
      pend_wr     <= 1'b0;
      ext_read_q  <= 1'b0;
      ext_write_q <= 1'b0;
    end else begin
      // request strobes one cycle after the start
      ext_read_q  <= mem_start_rd;
      ext_write_q <= mem_start_wr;
      if (mem_start_rd) begin
        pend_rd <= 1'b1;
      end else if (halt_any || mem_done_rd) begin
        pend_rd <= 1'b0;
      end
      if (mem_start_wr) begin
        pend_wr <= 1'b1;
      end else if (halt_any || mem_done_wr) begin
        pend_wr <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_clear) begin
      req_addr <= '0;
      req_data <= '0;
      addr_out <= '0;
      data_out <= '0;
    end else begin
      if (mem_start_rd || mem_start_wr) begin
        req_addr <= addr_in;
      end
      if (mem_start_wr) begin
        req_data <= data_in;
      end
      // memory's answer for the cpu
      if (mem_done_rd || mem_done_wr) begin
        addr_out <= ext_mem_addr_in;
        data_out <= ext_mem_data_in;
      end
    end
  end

endmodule

// ==== src/cpu_scheduler.sv ====
`timescale 1ns/1ps

`include "dispatcher_cfg.svh"

module cpu_scheduler (
  input  logic                     clk,
  input  logic                     ext_rst_e,
  input  logic                     sched_step,
  input  logic                     sched_msg_ev,
  input  dispatcher_pkg::cpu_msg_t cpu_msg_in,
  output dispatcher_pkg::cpu_idx_t ext_cpu_index
);

  dispatcher_pkg::cpu_cnt_t cnt_act;
  dispatcher_pkg::cpu_cnt_t cnt_inact;
  dispatcher_pkg::cpu_cnt_t cpu_num;
  // set after a restart slot was offered
  logic                     restart_slot;

  dispatcher_pkg::cpu_cnt_t num_inc;
  dispatcher_pkg::cpu_cnt_t last_num;

  assign num_inc  = cpu_num + dispatcher_pkg::cpu_cnt_t'(1);
  // wraps to all ones with no active cpu
  assign last_num = cnt_act - dispatcher_pkg::cpu_cnt_t'(1);

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      cnt_act       <= '0;
      cnt_inact     <= dispatcher_pkg::cpu_cnt_t'(`DISP_CPU_QUANTITY);
      cpu_num       <= '0;
      restart_slot  <= 1'b0;
      ext_cpu_index <= '0;
    end else if (sched_step) begin
      if ((cnt_inact != '0) && !restart_slot) begin
        // give an idle cpu the chance to start
        ext_cpu_index <= `DISP_CPU_NONACTIVE;
        restart_slot  <= 1'b1;
      end else begin
        restart_slot <= 1'b0;
        // round robin over active cpus
        if (cpu_num >= last_num) begin
          cpu_num       <= '0;
          ext_cpu_index <= `DISP_CPU_ACTIVE;
        end else begin
          cpu_num       <= num_inc;
          ext_cpu_index <= num_inc | `DISP_CPU_ACTIVE;
        end
      end
    end else if (sched_msg_ev) begin
      case (cpu_msg_in)
        dispatcher_pkg::msg_start: begin
          cnt_inact    <= cnt_inact - dispatcher_pkg::cpu_cnt_t'(1);
          cnt_act      <= cnt_act + dispatcher_pkg::cpu_cnt_t'(1);
          cpu_num      <= num_inc;
          restart_slot <= 1'b0;
        end
        dispatcher_pkg::msg_end: begin
          cnt_act   <= cnt_act - dispatcher_pkg::cpu_cnt_t'(1);
          cnt_inact <= cnt_inact + dispatcher_pkg::cpu_cnt_t'(1);
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== src/dispatch_ctl.sv ====
`timescale 1ns/1ps

`include "dispatcher_cfg.svh"

module dispatch_ctl (
  input  logic                     clk,
  input  logic                     ext_rst_e,
  input  logic                     read_q,
  input  logic                     write_q,
  input  logic                     ext_cpu_e,
  input  dispatcher_pkg::cpu_msg_t cpu_msg_in,
  input  logic                     ext_bus_q,
  input  logic                     mem_done_rd,
  input  logic                     mem_done_wr,
  input  logic                     mem_halt_cpu,
  input  logic                     mem_halt_ext,
  output logic                     ext_rst_b,
  output logic                     ext_cpu_q,
  output logic                     ext_bus_allow,
  output logic                     read_dn,
  output logic                     write_dn,
  output logic                     rw_halt_out,
  output logic                     ext_rw_halt_out,
  output logic                     sched_step,
  output logic                     sched_msg_ev,
  output logic                     mem_start_rd,
  output logic                     mem_start_wr,
  output logic                     mem_clear
);

  dispatcher_pkg::ctl_state_t state;

  logic in_loop;
  logic in_cmd;
  logic msg_counted;

  assign in_loop = (state == dispatcher_pkg::st_cpu_loop);
  assign in_cmd  = (state == dispatcher_pkg::st_cpu_cmd);

  // only start and end change the cpu counts
  assign msg_counted = (cpu_msg_in == dispatcher_pkg::msg_start) ||
                       (cpu_msg_in == dispatcher_pkg::msg_end);

  // poll only when no bus request and the cpus are idle
  assign sched_step = in_loop && !ext_bus_q && !ext_cpu_e;

  // command decode: read, then write, then message
  assign mem_start_rd = in_cmd && read_q;
  assign mem_start_wr = in_cmd && !read_q && write_q;
  assign sched_msg_ev = in_cmd && !read_q && !write_q && ext_cpu_e && msg_counted;

  // results dropped in the finish cycle
  assign mem_clear = (state == dispatcher_pkg::st_mem_finish);

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state           <= dispatcher_pkg::st_reset_wait;
      ext_rst_b       <= 1'b1;
      ext_cpu_q       <= 1'b0;
      ext_bus_allow   <= 1'b0;
      read_dn         <= 1'b0;
      write_dn        <= 1'b0;
      rw_halt_out     <= 1'b0;
      ext_rw_halt_out <= 1'b0;
    end else begin
      // single-cycle strobes
      ext_cpu_q       <= 1'b0;
      read_dn         <= 1'b0;
      write_dn        <= 1'b0;
      rw_halt_out     <= 1'b0;
      ext_rw_halt_out <= 1'b0;

      case (state)
        dispatcher_pkg::st_reset_wait: begin
          // let the cpus out of reset
          ext_rst_b <= 1'b0;
          state     <= dispatcher_pkg::st_cpu_loop;
        end

        dispatcher_pkg::st_cpu_loop: begin
          // external master wins over polling
          if (ext_bus_q) begin
            state <= dispatcher_pkg::st_ext_bus;
          end else if (!ext_cpu_e) begin
            ext_cpu_q <= 1'b1;
            state     <= dispatcher_pkg::st_cpu_cmd;
          end
        end

        dispatcher_pkg::st_cpu_cmd: begin
          // wait for the polled cpu
          if (read_q || write_q) begin
            state <= dispatcher_pkg::st_mem_work;
          end else if (ext_cpu_e) begin
            state <= dispatcher_pkg::st_cpu_loop;
          end
        end

        dispatcher_pkg::st_mem_work: begin
          // halt from the cpu goes to memory, and the reverse
          if (mem_halt_cpu) begin
            ext_rw_halt_out <= 1'b1;
            state           <= dispatcher_pkg::st_mem_finish;
          end else if (mem_halt_ext) begin
            rw_halt_out <= 1'b1;
            state       <= dispatcher_pkg::st_mem_finish;
          end else if (mem_done_rd) begin
            read_dn <= 1'b1;
            state   <= dispatcher_pkg::st_mem_finish;
          end else if (mem_done_wr) begin
            write_dn <= 1'b1;
            state    <= dispatcher_pkg::st_mem_finish;
          end
        end

        dispatcher_pkg::st_mem_finish: begin
          state <= dispatcher_pkg::st_cpu_loop;
        end

        dispatcher_pkg::st_ext_bus: begin
          // grant follows the request one cycle late
          ext_bus_allow <= ext_bus_q;
          if (!ext_bus_q) begin
            state <= dispatcher_pkg::st_cpu_loop;
          end
        end

        default: begin
          state <= dispatcher_pkg::st_reset_wait;
        end
      endcase
    end
  end

endmodule

// ==== common/dispatcher_pkg.sv ====
`include "dispatcher_cfg.svh"

package dispatcher_pkg;

  // controller states
  typedef enum logic [2:0] {
    st_reset_wait,
    st_cpu_loop,
    st_cpu_cmd,
    st_mem_work,
    st_mem_finish,
    st_ext_bus
  } ctl_state_t;

  // messages reported by the polled cpu
  typedef enum logic [`DISP_MSG_W-1:0] {
    msg_none  = `DISP_MSG_NONE,
    msg_reset = `DISP_MSG_RESET,
    msg_start = `DISP_MSG_START,
    msg_end   = `DISP_MSG_END
  } cpu_msg_t;

  // index shown to the cpus with each poll
  typedef logic [`DISP_IDX_W-1:0] cpu_idx_t;

  // active / inactive counters and cpu number
  typedef logic [`DISP_CNT_W-1:0] cpu_cnt_t;

endpackage

// ==== common/dispatcher_cfg.svh ====
`ifndef DISPATCHER_CFG_SVH
`define DISPATCHER_CFG_SVH

// cpu and memory bus widths
`define DISP_ADDR_W 32
`define DISP_DATA_W 32

// size of the cpu pool
`define DISP_CPU_QUANTITY 4

// cpu index and counter widths
`define DISP_IDX_W 8
`define DISP_CNT_W 8

// index flag, bit 7 marks an active cpu
`define DISP_CPU_ACTIVE 8'h80
// restart slot offered to an inactive cpu
`define DISP_CPU_NONACTIVE 8'h7F

// cpu message codes
`define DISP_MSG_W 8
`define DISP_MSG_NONE 8'h00
`define DISP_MSG_RESET 8'h01
`define DISP_MSG_START 8'h02
`define DISP_MSG_END 8'h03

`endif
